//--- hw/core_glue_pkg.sv
package core_glue_pkg;

    // Datapath widths.
    localparam int XLEN      = 32;
    localparam int REG_ID_W  = 5;
    localparam int BYTE_EN_W = 4;
    localparam int SIZE_W    = 3;

    // Boot sequencing.
    localparam int RESET_HOLD_CYCLES = 128;
    localparam int WARMUP_FETCHES    = 3;
    localparam int HOLD_CNT_W        = $clog2(RESET_HOLD_CYCLES);
    localparam int FETCH_CNT_W       = $clog2(WARMUP_FETCHES);

    // Target field of a CACHE instruction, bits 17:16.
    localparam logic [1:0] CACHE_TGT_I = 2'b00;
    localparam logic [1:0] CACHE_TGT_D = 2'b01;

    // Transfer size codes on the uncached port.
    localparam logic [SIZE_W-1:0] SIZE_BYTE = 3'd0;
    localparam logic [SIZE_W-1:0] SIZE_HALF = 3'd1;
    localparam logic [SIZE_W-1:0] SIZE_WORD = 3'd2;

    typedef enum logic [1:0] {
        RST_HOLD = 2'd0,
        WARMUP   = 2'd1,
        RUN      = 2'd2
    } boot_state_e;

    typedef enum logic [2:0] {
        CACHE_NOP                       = 3'd0,
        CACHE_INDEX_WRITEBACK_INVALIDATE = 3'd1,
        CACHE_INDEX_STORE_TAG           = 3'd2,
        CACHE_HIT_INVALIDATE            = 3'd3,
        CACHE_HIT_WRITEBACK_INVALIDATE  = 3'd4
    } cache_op_e;

    typedef enum logic [1:0] {
        MW_BYTE = 2'd0,
        MW_HALF = 2'd1,
        MW_WORD = 2'd2
    } mem_width_e;

    typedef struct packed {
        logic                 rd;
        logic                 wr;
        logic                 uncached;
        logic                 exc_pending;  // Exception raised by this access.
        logic [XLEN-1:0]      addr;
        logic [XLEN-1:0]      wdata;
        logic [BYTE_EN_W-1:0] byte_en;
        mem_width_e           width;
    } dmem_req_t;

    typedef struct packed {
        logic                 rd;
        logic                 wr;
        logic [XLEN-1:0]      addr;
        logic [XLEN-1:0]      wdata;
        logic [BYTE_EN_W-1:0] byte_en;
    } cached_req_t;

    typedef struct packed {
        cached_req_t       base;
        logic [SIZE_W-1:0] size;
    } uncached_req_t;

    typedef struct packed {
        logic [XLEN-1:0]     pc;
        logic [XLEN-1:0]     data;
        logic [REG_ID_W-1:0] reg_id;
        logic                wr_en;
    } wb_rec_t;

    typedef struct packed {
        logic [XLEN-1:0]      pc;
        logic [BYTE_EN_W-1:0] rf_wen;  // One bit per byte lane.
        logic [REG_ID_W-1:0]  rf_wnum;
        logic [XLEN-1:0]      rf_wdata;
    } trace_t;

endpackage

//--- hw/boot_ctrl.sv
module boot_ctrl
    import core_glue_pkg::*;
(
    input  logic Clk,
    input  logic Myreset,
    input  logic i_inst_data_ok,
    input  logic i_dcache_close,
    output logic o_core_reset,
    output logic o_icache_close,
    output logic o_total_uncache
);

    boot_state_e state;
    boot_state_e state_nxt;

    logic [HOLD_CNT_W-1:0]  hold_cnt;
    logic [FETCH_CNT_W-1:0] fetch_cnt;
    logic                   hold_done;
    logic                   warmup_done;

    // Last edge of the hold window.
    assign hold_done = (hold_cnt == HOLD_CNT_W'(RESET_HOLD_CYCLES - 1));

    // Final uncached fetch completes.
    assign warmup_done = i_inst_data_ok &&
                         (fetch_cnt == FETCH_CNT_W'(WARMUP_FETCHES - 1));

    always_comb begin
        state_nxt = state;
        case (state)
            RST_HOLD: begin
                if (hold_done) begin
                    state_nxt = WARMUP;
                end
            end
            WARMUP: begin
                if (warmup_done) begin
                    state_nxt = RUN;
                end
            end
            RUN: begin
                state_nxt = RUN;
            end
            default: begin
                state_nxt = RST_HOLD;
            end
        endcase
    end

    always_ff @(posedge Clk) begin
        if (Myreset) begin
            state     <= RST_HOLD;
            hold_cnt  <= '0;
            fetch_cnt <= '0;
        end else begin
            state <= state_nxt;
            if (state == RST_HOLD) begin
                hold_cnt <= hold_cnt + HOLD_CNT_W'(1);
            end
            // Fetches only count once the core is out of reset.
            if (state == WARMUP && i_inst_data_ok) begin
                fetch_cnt <= fetch_cnt + FETCH_CNT_W'(1);
            end
        end
    end

    assign o_core_reset    = (state == RST_HOLD);
    assign o_icache_close  = (state != RUN);  // Closed through hold and warm-up.
    assign o_total_uncache = o_icache_close | i_dcache_close;

endmodule

//--- hw/cache_op_decode.sv
module cache_op_decode
    import core_glue_pkg::*;
(
    input  logic            i_cache_instr,
    input  logic [XLEN-1:0] i_cache_word,
    output cache_op_e       o_icache_op,
    output cache_op_e       o_dcache_op
);

    logic [1:0] target;
    logic [2:0] op_field;

    assign target   = i_cache_word[17:16];
    assign op_field = i_cache_word[20:18];

    // Same table for both caches, hit writeback only exists on the D side.
    function automatic cache_op_e decode_op(input logic [2:0] op, input logic is_dcache);
        cache_op_e res;
        case (op)
            3'b000: begin
                res = CACHE_INDEX_WRITEBACK_INVALIDATE;
            end
            3'b010: begin
                res = CACHE_INDEX_STORE_TAG;
            end
            3'b100: begin
                res = CACHE_HIT_INVALIDATE;
            end
            3'b101: begin
                res = is_dcache ? CACHE_HIT_WRITEBACK_INVALIDATE : CACHE_NOP;
            end
            default: begin
                res = CACHE_NOP;
            end
        endcase
        return res;
    endfunction

    always_comb begin
        o_icache_op = CACHE_NOP;
        o_dcache_op = CACHE_NOP;
        if (i_cache_instr) begin
            if (target == CACHE_TGT_I) begin
                o_icache_op = decode_op(op_field, 1'b0);
            end
            if (target == CACHE_TGT_D) begin
                o_dcache_op = decode_op(op_field, 1'b1);
            end
        end
    end

endmodule

//--- hw/dmem_req_route.sv
module dmem_req_route
    import core_glue_pkg::*;
(
    input  dmem_req_t     i_req,
    input  logic          i_total_uncache,
    output cached_req_t   o_cached_req,
    output uncached_req_t o_uncached_req
);

    logic              to_uncached;
    logic              rd_ok;
    logic              wr_ok;
    logic [SIZE_W-1:0] size_code;

    // Uncached by page attribute, or while caches are closed.
    assign to_uncached = i_req.uncached | i_total_uncache;

    // A faulting access must not reach memory.
    assign rd_ok = i_req.rd & ~i_req.exc_pending;
    assign wr_ok = i_req.wr & ~i_req.exc_pending;

    always_comb begin
        case (i_req.width)
            MW_WORD: begin
                size_code = SIZE_WORD;
            end
            MW_HALF: begin
                size_code = SIZE_HALF;
            end
            default: begin
                size_code = SIZE_BYTE;
            end
        endcase
    end

    always_comb begin
        o_cached_req.rd      = rd_ok & ~to_uncached;
        o_cached_req.wr      = wr_ok & ~to_uncached;
        o_cached_req.addr    = i_req.addr;
        o_cached_req.wdata   = i_req.wdata;
        o_cached_req.byte_en = i_req.byte_en;
    end

    always_comb begin
        o_uncached_req.base.rd      = rd_ok & to_uncached;
        o_uncached_req.base.wr      = wr_ok & to_uncached;
        o_uncached_req.base.addr    = i_req.addr;
        o_uncached_req.base.wdata   = i_req.wdata;
        o_uncached_req.base.byte_en = i_req.byte_en;
        o_uncached_req.size         = size_code;  // Bus size follows access width.
    end

endmodule

//--- hw/wb_trace.sv
module wb_trace
    import core_glue_pkg::*;
(
    input  logic    Clk,
    input  logic    i_core_reset,
    input  wb_rec_t i_wb,
    input  logic    i_flush,
    input  logic    i_dm_stall,
    input  logic    i_exc_now,
    output trace_t  o_trace
);

    logic   wen_ok;
    trace_t trace_nxt;

    // A stalled writeback only retires when an exception is taken.
    assign wen_ok = i_wb.wr_en & ~i_flush & (~i_dm_stall | i_exc_now);

    always_comb begin
        if (i_flush) begin
            trace_nxt.pc       = '0;
            trace_nxt.rf_wnum  = '0;
            trace_nxt.rf_wdata = '0;
        end else begin
            trace_nxt.pc       = i_wb.pc;
            trace_nxt.rf_wnum  = i_wb.reg_id;
            trace_nxt.rf_wdata = i_wb.data;
        end
        trace_nxt.rf_wen = wen_ok ? '1 : '0;
    end

    always_ff @(posedge Clk) begin
        if (i_core_reset) begin
            o_trace <= '0;
        end else begin
            o_trace <= trace_nxt;
        end
    end

endmodule

//--- hw/core_glue_top.sv
module core_glue_top
    import core_glue_pkg::*;
(
    input  logic            Clk,
    input  logic            Myreset,

    // Boot and cache warm-up.
    input  logic            i_inst_data_ok,
    input  logic            i_dcache_close,
    output logic            o_core_reset,
    output logic            o_icache_close,
    output logic            o_total_uncache,

    // CACHE instruction.
    input  logic            i_cache_instr,
    input  logic [XLEN-1:0] i_cache_word,
    output cache_op_e       o_icache_op,
    output cache_op_e       o_dcache_op,

    // Data memory requests.
    input  dmem_req_t       i_dmem_req,
    output cached_req_t     o_cached_req,
    output uncached_req_t   o_uncached_req,

    // Writeback trace.
    input  wb_rec_t         i_wb,
    input  logic            i_flush,
    input  logic            i_dm_stall,
    input  logic            i_exc_now,
    output trace_t          o_trace
);

    boot_ctrl boot_ctrl_inst (
        .Clk             (Clk),
        .Myreset         (Myreset),
        .i_inst_data_ok  (i_inst_data_ok),
        .i_dcache_close  (i_dcache_close),
        .o_core_reset    (o_core_reset),
        .o_icache_close  (o_icache_close),
        .o_total_uncache (o_total_uncache)
    );

    cache_op_decode cache_op_decode_inst (
        .i_cache_instr (i_cache_instr),
        .i_cache_word  (i_cache_word),
        .o_icache_op   (o_icache_op),
        .o_dcache_op   (o_dcache_op)
    );

    // Closed caches force every data access uncached.
    dmem_req_route dmem_req_route_inst (
        .i_req           (i_dmem_req),
        .i_total_uncache (o_total_uncache),
        .o_cached_req    (o_cached_req),
        .o_uncached_req  (o_uncached_req)
    );

    wb_trace wb_trace_inst (
        .Clk          (Clk),
        .i_core_reset (o_core_reset),  // Trace stays quiet while the core is held.
        .i_wb         (i_wb),
        .i_flush      (i_flush),
        .i_dm_stall   (i_dm_stall),
        .i_exc_now    (i_exc_now),
        .o_trace      (o_trace)
    );

endmodule

//--- tb/core_glue_tests.svh
task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
        $display("error: %s got 0x%h expected 0x%h", name, got, exp);
        err_count++;
    end
endtask

task automatic check_op(input string name, input cache_op_e got, input cache_op_e exp);
    if (got !== exp) begin
        $display("error: %s got 0x%h expected 0x%h", name, got, exp);
        err_count++;
    end
endtask

task automatic check_cached(input string name, input cached_req_t got, input cached_req_t exp);
    if (got !== exp) begin
        $display("error: %s got 0x%h expected 0x%h", name, got, exp);
        err_count++;
    end
endtask

task automatic check_uncached(input string name, input uncached_req_t got,
                              input uncached_req_t exp);
    if (got !== exp) begin
        $display("error: %s got 0x%h expected 0x%h", name, got, exp);
        err_count++;
    end
endtask

task automatic check_trace(input string name, input trace_t got, input trace_t exp);
    if (got !== exp) begin
        $display("error: %s got 0x%h expected 0x%h", name, got, exp);
        err_count++;
    end
endtask

task automatic report_test(input string name, input int errs_start);
    if (err_count == errs_start) begin
        tests_passed++;
        $display("%s: passed", name);
    end else begin
        tests_failed++;
        $display("%s: FAILED with %0d errors", name, err_count - errs_start);
    end
endtask

// Decode table of CACHE instructions per target cache.
function automatic cache_op_e expected_op(input logic instr, input logic [1:0] tgt,
                                          input logic [2:0] op, input logic [1:0] cache_sel);
    if (!instr || tgt != cache_sel) begin
        return CACHE_NOP;
    end
    case (op)
        3'd0: return CACHE_INDEX_WRITEBACK_INVALIDATE;
        3'd2: return CACHE_INDEX_STORE_TAG;
        3'd4: return CACHE_HIT_INVALIDATE;
        3'd5: return (cache_sel == 2'd1) ? CACHE_HIT_WRITEBACK_INVALIDATE : CACHE_NOP;
        default: return CACHE_NOP;
    endcase
endfunction

function automatic logic [2:0] bus_size(input mem_width_e w);
    case (w)
        MW_WORD: return 3'd2;
        MW_HALF: return 3'd1;
        default: return 3'd0;
    endcase
endfunction

task automatic stretch_reset_check();
    int errs_start;
    errs_start = err_count;
    i_wb.pc     = rand_bits(32);
    i_wb.data   = rand_bits(32);
    i_wb.reg_id = 5'(rand_bits(5));
    i_wb.wr_en  = 1'b1;
    for (int i = 0; i < RESET_HOLD_CYCLES; i++) begin
        check_bit("o_core_reset", o_core_reset, 1'b1);
        check_bit("o_icache_close", o_icache_close, 1'b1);
        check_trace("o_trace", o_trace, '0);
        // Fetch pulses through the hold window and on its final edge.
        i_inst_data_ok = (i % 4 == 1) || (i == RESET_HOLD_CYCLES - 1);
        @(negedge Clk);
    end
    i_inst_data_ok = 1'b0;
    i_wb = '0;
    check_bit("o_core_reset", o_core_reset, 1'b0);
    check_bit("o_icache_close", o_icache_close, 1'b1);
    check_trace("o_trace", o_trace, '0);
    report_test("reset stretch", errs_start);
endtask

task automatic warmup_sequence();
    int errs_start;
    int pulses;
    errs_start = err_count;
    pulses = 0;
    check_bit("o_icache_close", o_icache_close, 1'b1);
    for (int k = 0; k < WARMUP_FETCHES; k++) begin
        i_inst_data_ok = 1'b1;
        @(negedge Clk);
        i_inst_data_ok = 1'b0;
        pulses++;
        exp_icache_close = (pulses < WARMUP_FETCHES);
        check_bit("o_icache_close", o_icache_close, exp_icache_close);
        repeat (k + 1) begin
            @(negedge Clk);
            check_bit("o_icache_close", o_icache_close, exp_icache_close);
        end
    end
    for (int d = 0; d < 2; d++) begin
        i_dcache_close = d[0];
        #10;
        check_bit("o_total_uncache", o_total_uncache, exp_icache_close | d[0]);
        @(negedge Clk);
    end
    i_dcache_close = 1'b0;
    report_test("cache warm-up", errs_start);
endtask

task automatic route_requests(input int count, input string name);
    int            errs_start;
    dmem_req_t     req;
    logic [1:0]    w;
    logic          dclose;
    logic          to_unc;
    cached_req_t   exp_c;
    uncached_req_t exp_u;
    errs_start = err_count;
    for (int n = 0; n < count; n++) begin
        req.rd          = 1'(rand_bits(1));
        req.wr          = 1'(rand_bits(1));
        req.uncached    = 1'(rand_bits(1));
        req.exc_pending = (2'(rand_bits(2)) == 2'b11);  // Roughly one request in four.
        req.addr        = rand_bits(32);
        req.wdata       = rand_bits(32);
        req.byte_en     = 4'(rand_bits(4));
        w               = 2'(rand_bits(2));
        req.width       = (w == 2'd0) ? MW_BYTE : ((w == 2'd1) ? MW_HALF : MW_WORD);
        dclose          = 1'(rand_bits(1));
        i_dmem_req      = req;
        i_dcache_close  = dclose;
        #10;
        to_unc        = req.uncached | exp_icache_close | dclose;
        exp_c.addr    = req.addr;
        exp_c.wdata   = req.wdata;
        exp_c.byte_en = req.byte_en;
        exp_c.rd      = req.rd & ~req.exc_pending & ~to_unc;
        exp_c.wr      = req.wr & ~req.exc_pending & ~to_unc;
        exp_u.base    = exp_c;
        exp_u.base.rd = req.rd & ~req.exc_pending & to_unc;
        exp_u.base.wr = req.wr & ~req.exc_pending & to_unc;
        exp_u.size    = bus_size(req.width);
        check_cached("o_cached_req", o_cached_req, exp_c);
        check_uncached("o_uncached_req", o_uncached_req, exp_u);
        @(negedge Clk);
    end
    i_dmem_req = '0;
    i_dcache_close = 1'b0;
    report_test(name, errs_start);
endtask

task automatic decode_cache_ops();
    int          errs_start;
    logic [31:0] word;
    errs_start = err_count;
    i_cache_instr = 1'b1;
    for (int t = 0; t < 4; t++) begin
        for (int op = 0; op < 8; op++) begin
            word = rand_bits(32);
            word[17:16] = 2'(t);
            word[20:18] = 3'(op);
            i_cache_word = word;
            #10;
            check_op("o_icache_op", o_icache_op, expected_op(1'b1, 2'(t), 3'(op), 2'd0));
            check_op("o_dcache_op", o_dcache_op, expected_op(1'b1, 2'(t), 3'(op), 2'd1));
            @(negedge Clk);
        end
    end
    // A D-cache hit invalidate word that is not a CACHE instruction.
    i_cache_instr = 1'b0;
    word = rand_bits(32);
    word[20:16] = 5'b10001;
    i_cache_word = word;
    #10;
    check_op("o_icache_op", o_icache_op, CACHE_NOP);
    check_op("o_dcache_op", o_dcache_op, CACHE_NOP);
    @(negedge Clk);
    i_cache_word = '0;
    report_test("cache decode", errs_start);
endtask

task automatic trace_writebacks();
    int         errs_start;
    wb_rec_t    rec;
    trace_t     exp_tr;
    logic [3:0] mode;
    errs_start = err_count;
    for (int m = 0; m < 16; m++) begin
        mode       = 4'(m);  // Write flag, flush, stall, exception.
        rec.pc     = rand_bits(32);
        rec.data   = rand_bits(32);
        rec.reg_id = 5'(rand_bits(5));
        rec.wr_en  = mode[3];
        i_wb       = rec;
        i_flush    = mode[2];
        i_dm_stall = mode[1];
        i_exc_now  = mode[0];
        exp_tr.rf_wen   = (mode[3] & ~mode[2] & (~mode[1] | mode[0])) ? 4'hf : 4'h0;
        exp_tr.pc       = mode[2] ? '0 : rec.pc;
        exp_tr.rf_wdata = mode[2] ? '0 : rec.data;
        exp_tr.rf_wnum  = mode[2] ? '0 : rec.reg_id;
        @(negedge Clk);
        check_trace("o_trace", o_trace, exp_tr);
    end
    i_wb       = '0;
    i_flush    = 1'b0;
    i_dm_stall = 1'b0;
    i_exc_now  = 1'b0;
    report_test("writeback trace", errs_start);
endtask

//--- tb/core_glue_tb.sv
module core_glue_tb
    import core_glue_pkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int CLK_PERIOD      = 100;
    localparam int RESET_TEST_LEN  = 4;
    localparam int WARMUP_TEST_LEN = 12;
    localparam int ROUTE_TEST_LEN  = 40;
    localparam int DECODE_TEST_LEN = 33;
    localparam int TRACE_TEST_LEN  = 17;
    localparam int WATCHDOG_CYCLES = 2 * (RESET_TEST_LEN + WARMUP_TEST_LEN + ROUTE_TEST_LEN +
                                          DECODE_TEST_LEN + TRACE_TEST_LEN + RESET_HOLD_CYCLES);

    logic            Clk;
    logic            Myreset;
    logic            i_inst_data_ok;
    logic            i_dcache_close;
    logic            i_cache_instr;
    logic [XLEN-1:0] i_cache_word;
    dmem_req_t       i_dmem_req;
    wb_rec_t         i_wb;
    logic            i_flush;
    logic            i_dm_stall;
    logic            i_exc_now;
    logic            o_core_reset;
    logic            o_icache_close;
    logic            o_total_uncache;
    cache_op_e       o_icache_op;
    cache_op_e       o_dcache_op;
    cached_req_t     o_cached_req;
    uncached_req_t   o_uncached_req;
    trace_t          o_trace;

    logic [15:0] lfsr_state;
    int          err_count;
    int          tests_passed;
    int          tests_failed;
    logic        exp_icache_close;  // Expected warm-up state of the I-cache.

    core_glue_top core_glue_top_inst (
        .Clk             (Clk),
        .Myreset         (Myreset),
        .i_inst_data_ok  (i_inst_data_ok),
        .i_dcache_close  (i_dcache_close),
        .o_core_reset    (o_core_reset),
        .o_icache_close  (o_icache_close),
        .o_total_uncache (o_total_uncache),
        .i_cache_instr   (i_cache_instr),
        .i_cache_word    (i_cache_word),
        .o_icache_op     (o_icache_op),
        .o_dcache_op     (o_dcache_op),
        .i_dmem_req      (i_dmem_req),
        .o_cached_req    (o_cached_req),
        .o_uncached_req  (o_uncached_req),
        .i_wb            (i_wb),
        .i_flush         (i_flush),
        .i_dm_stall      (i_dm_stall),
        .i_exc_now       (i_exc_now),
        .o_trace         (o_trace)
    );

    initial Clk = 1'b0;
    always #(CLK_PERIOD / 2) Clk = ~Clk;

    // 16-bit Fibonacci LFSR, taps 16 14 13 11.
    function automatic logic lfsr_bit();
        logic fb;
        fb = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
        lfsr_state = {lfsr_state[14:0], fb};
        return fb;
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] val;
        val = '0;
        for (int i = 0; i < n; i++) begin
            val = {val[30:0], lfsr_bit()};
        end
        return val;
    endfunction

    `include "core_glue_tests.svh"

    initial begin
        lfsr_state       = 16'd77;
        err_count        = 0;
        tests_passed     = 0;
        tests_failed     = 0;
        exp_icache_close = 1'b1;
        Myreset          = 1'b1;
        i_inst_data_ok   = 1'b0;
        i_dcache_close   = 1'b0;
        i_cache_instr    = 1'b0;
        i_cache_word     = '0;
        i_dmem_req       = '0;
        i_wb             = '0;
        i_flush          = 1'b0;
        i_dm_stall       = 1'b0;
        i_exc_now        = 1'b0;
        repeat (3) @(posedge Clk);
        @(negedge Clk);
        Myreset = 1'b0;

        stretch_reset_check();
        route_requests(20, "routing before warm-up");
        warmup_sequence();
        route_requests(20, "routing after warm-up");
        decode_cache_ops();
        trace_writebacks();

        $display("tests passed: %0d, tests failed: %0d", tests_passed, tests_failed);
        if (tests_failed == 0 && err_count == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge Clk);
        $display("watchdog: run did not end within %0d clock periods", WATCHDOG_CYCLES);
        $display("Test failed");
        $finish;
    end

endmodule

//--- verilog.f
+incdir+tb
hw/core_glue_pkg.sv
hw/boot_ctrl.sv
hw/cache_op_decode.sv
hw/dmem_req_route.sv
hw/wb_trace.sv
hw/core_glue_top.sv
tb/core_glue_tb.sv

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/100ps \
    -f verilog.f --top-module core_glue_tb \
    --Mdir obj_dir -o core_glue_sim

./obj_dir/core_glue_sim > sim.log
cat sim.log

if grep -q "Test completed successfully" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi
